/* sources.f */
verilog/rom_loader_pkg.sv
verilog/region_table.sv
verilog/region_map.sv
verilog/dl_writer.sv
verilog/colour_prom.sv
verilog/rom_loader_top.sv
testbench/tb_checker.sv
testbench/tb_rom_loader.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := tb_rom_loader
FILELIST  := sources.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_rom_loader.sv */
// Testbench for the ROM download path.
// Covers default regions, object reorder, a moved region table,
// colour PROM fill with palette read-back, and overrun.
// SDRAM acknowledge comes 1 to 4 cycles after each write request.

`timescale 1ns/1ps
`default_nettype none

module tb_rom_loader;

    localparam int N_RAND  = 48;
    localparam int N_OBJ   = 40;
    localparam int N_PROM  = 512;
    localparam int N_PAL   = 256;
    // Table writes, boundary bytes, dropped and overrun bytes
    localparam int N_OTHER = 40;
    localparam int WATCHDOG_CYCLES = (N_RAND + N_OBJ + N_PROM + N_PAL + N_OTHER) * 12 + 200;

    integer                    seed = 87;
    logic                      clk;
    logic                      arst_n;
    logic                      cfg_wr;
    rom_loader_pkg::cfg_wr_t   cfg;
    logic                      downloading;
    logic [24:0]               ioctl_addr;
    logic [7:0]                ioctl_dout;
    logic                      ioctl_wr;
    rom_loader_pkg::sdram_wr_t prog;
    logic                      prog_we;
    logic                      sdram_ack;
    logic                      dwnld_busy;
    logic                      dl_overrun;
    logic                      pal_rd;
    logic [7:0]                pal_idx;
    rom_loader_pkg::rgb_t      pal_rgb;
    logic                      pal_valid;
    int                        err_count;
    int                        check_count;

    rom_loader_top i_rom_loader_top (.*);

    tb_checker i_checker (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the test sequence hung", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    // SDRAM model with one ack pulse per write request
    initial begin
        int delay;
        sdram_ack = 1'b0;
        forever begin
            @(posedge prog_we);
            delay = ($random(seed) & 3) + 1;
            repeat (delay) @(negedge clk);
            sdram_ack = 1'b1;
            @(negedge clk);
            sdram_ack = 1'b0;
        end
    end

    task automatic send_byte(input logic [21:0] addr, input logic [7:0] data, input int gap);
        @(negedge clk);
        ioctl_addr = {3'b000, addr};
        ioctl_dout = data;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        repeat (gap) @(negedge clk);
        // Let the SDRAM write retire before the next byte
        while (prog_we) @(negedge clk);
    endtask

    task automatic write_cfg(input rom_loader_pkg::region_e sel, input logic [21:0] start);
        @(negedge clk);
        cfg_wr    = 1'b1;
        cfg.sel   = sel;
        cfg.start = start;
        @(negedge clk);
        cfg_wr = 1'b0;
    endtask

    task automatic read_pal(input logic [7:0] idx);
        @(negedge clk);
        pal_rd  = 1'b1;
        pal_idx = idx;
        @(negedge clk);
        pal_rd = 1'b0;
    endtask

    initial begin
        int r;
        int a;
        int base;
        arst_n      = 1'b0;
        cfg_wr      = 1'b0;
        cfg         = '0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        pal_rd      = 1'b0;
        pal_idx     = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        downloading = 1'b1;

        // Code, scroll and PCM with default offsets
        for (int i = 0; i < N_RAND; i++) begin
            r    = $random(seed);
            base = (i % 3 == 0) ? 0 : ((i % 3 == 1) ? 32'h8000 : 32'h1_8000);
            a    = base + (r & 32'h7FFF);
            send_byte(a[21:0], r[23:16], 6);
        end

        // Object region covering every value of the low five bits
        for (int i = 0; i < N_OBJ; i++) begin
            r = $random(seed);
            a = 32'h1_0000 + (r & 32'h7FE0) + (i % 32);
            send_byte(a[21:0], r[7:0], 6);
        end

        // The REG_CODE write comes last so a stray update would move a visible bound
        write_cfg(rom_loader_pkg::REG_SCR, 22'h00_4000);
        write_cfg(rom_loader_pkg::REG_OBJ, 22'h00_C000);
        write_cfg(rom_loader_pkg::REG_PCM, 22'h01_4000);
        write_cfg(rom_loader_pkg::REG_PROM, 22'h01_C000);
        write_cfg(rom_loader_pkg::REG_CODE, 22'h00_0000);
        for (int b = 1; b <= 4; b++) begin
            for (int d = -1; d <= 1; d++) begin
                r = $random(seed);
                a = b * 32'h8000 - 32'h4000 + d;
                send_byte(a[21:0], r[7:0], 6);
            end
        end
        write_cfg(rom_loader_pkg::REG_SCR, rom_loader_pkg::SCR_START_DEF);
        write_cfg(rom_loader_pkg::REG_OBJ, rom_loader_pkg::OBJ_START_DEF);
        write_cfg(rom_loader_pkg::REG_PCM, rom_loader_pkg::PCM_START_DEF);
        write_cfg(rom_loader_pkg::REG_PROM, rom_loader_pkg::PROM_START_DEF);

        // PROM fill followed by bytes that must not land
        for (int i = 0; i < N_PROM; i++) begin
            r = $random(seed);
            a = 32'h2_0000 + i;
            send_byte(a[21:0], r[7:0], 6);
        end
        for (int i = 0; i < 4; i++) begin
            a = 32'h2_0200 + i * 32'h81;
            send_byte(a[21:0], 8'hA5, 6);
        end
        downloading = 1'b0;
        for (int i = 0; i < 4; i++) begin
            a = 32'h2_0000 + i * 2;
            send_byte(a[21:0], 8'h5A, 6);
        end
        for (int i = 0; i < N_PAL; i++) begin
            read_pal(i[7:0]);
        end

        // Second byte while the first write is pending
        downloading = 1'b1;
        @(negedge clk);
        ioctl_addr = 25'h000_0100;
        ioctl_dout = 8'h3C;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_addr = 25'h000_0101;
        ioctl_dout = 8'hC3;
        @(negedge clk);
        ioctl_wr = 1'b0;
        while (prog_we) @(negedge clk);
        downloading = 1'b0;
        repeat (4) @(negedge clk);
        downloading = 1'b1;
        send_byte(22'h00_0200, 8'h77, 6);
        downloading = 1'b0;
        repeat (10) @(negedge clk);

        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/tb_checker.sv */
// Scoreboard for the ROM download path.
// Models prog_we, dl_overrun and pal_valid cycle by cycle from the
// stimulus it sees, with its own copy of the region table and PROM.
// Palette expectations assume no PROM byte lands just before a read.

`timescale 1ns/1ps
`default_nettype none

module tb_checker (
    input  wire                            clk,
    input  wire                            arst_n,
    input  wire                            cfg_wr,
    input  wire rom_loader_pkg::cfg_wr_t   cfg,
    input  wire                            downloading,
    input  wire [24:0]                     ioctl_addr,
    input  wire [7:0]                      ioctl_dout,
    input  wire                            ioctl_wr,
    input  wire                            sdram_ack,
    input  wire                            pal_rd,
    input  wire [7:0]                      pal_idx,
    input  wire rom_loader_pkg::sdram_wr_t prog,
    input  wire                            prog_we,
    input  wire                            dwnld_busy,
    input  wire                            dl_overrun,
    input  wire rom_loader_pkg::rgb_t      pal_rgb,
    input  wire                            pal_valid,
    output int                             err_count,
    output int                             check_count
);

    logic [21:0]               ref_scr;
    logic [21:0]               ref_obj;
    logic [21:0]               ref_pcm;
    logic [21:0]               ref_prom;
    logic [7:0]                ref_mem [512];
    logic                      exp_we;
    logic                      exp_ovr;
    logic                      exp_valid;
    logic                      dl_prev;
    rom_loader_pkg::sdram_wr_t exp_prog;
    rom_loader_pkg::rgb_t      exp_rgb;

    // Intervals taken in ascending order of start offset
    function automatic rom_loader_pkg::region_e region_of(input logic [21:0] a);
        if (a < ref_scr) return rom_loader_pkg::REG_CODE;
        if (a < ref_obj) return rom_loader_pkg::REG_SCR;
        if (a < ref_pcm) return rom_loader_pkg::REG_OBJ;
        if (a < ref_prom) return rom_loader_pkg::REG_PCM;
        return rom_loader_pkg::REG_PROM;
    endfunction

    function automatic logic [21:0] obj_reorder(input logic [21:0] a);
        return {a[21:5], a[2:0], ~a[4], ~a[3]};
    endfunction

    // Active low, even bytes on the upper lane
    function automatic logic [1:0] lane_mask(input logic odd);
        return odd ? 2'b10 : 2'b01;
    endfunction

    function automatic rom_loader_pkg::rgb_t pal_entry(input logic [7:0] idx);
        rom_loader_pkg::rgb_t c;
        c.red   = ref_mem[{idx, 1'b0}][7:4];
        c.green = ref_mem[{idx, 1'b0}][3:0];
        c.blue  = ref_mem[{idx, 1'b1}][3:0];
        return c;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act);
        check_count++;
        if (act !== exp_v) begin
            err_count++;
            $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp_v, act);
        end
    endtask

    always @(posedge clk) begin
        logic [21:0]             a;
        logic [21:0]             m;
        logic [21:0]             off;
        logic                    accept;
        rom_loader_pkg::region_e rg;
        if (!arst_n) begin
            ref_scr   = rom_loader_pkg::SCR_START_DEF;
            ref_obj   = rom_loader_pkg::OBJ_START_DEF;
            ref_pcm   = rom_loader_pkg::PCM_START_DEF;
            ref_prom  = rom_loader_pkg::PROM_START_DEF;
            exp_we    = 1'b0;
            exp_ovr   = 1'b0;
            exp_valid = 1'b0;
            dl_prev   = 1'b0;
        end else begin
            if (exp_we && !prog_we) begin
                err_count++;
                $display("At %0t an SDRAM write is pending but prog_we is low", $time);
            end else begin
                check_val("prog_we", 32'(exp_we), 32'(prog_we));
            end
            check_val("dwnld_busy", 32'(downloading | exp_we), 32'(dwnld_busy));
            check_val("dl_overrun", 32'(exp_ovr), 32'(dl_overrun));
            if (exp_we && prog_we) begin
                check_val("prog.addr", 32'(exp_prog.addr), 32'(prog.addr));
                check_val("prog.data", 32'(exp_prog.data), 32'(prog.data));
                check_val("prog.mask", 32'(exp_prog.mask), 32'(prog.mask));
            end
            if (exp_valid && !pal_valid) begin
                err_count++;
                $display("At %0t no pal_valid pulse followed a palette read", $time);
            end else if (!exp_valid && pal_valid) begin
                err_count++;
                $display("At %0t pal_valid pulsed without a palette read", $time);
            end else if (exp_valid) begin
                check_val("pal_rgb", 32'(exp_rgb), 32'(pal_rgb));
            end

            // Advance the model by this edge
            a      = ioctl_addr[21:0];
            rg     = region_of(a);
            accept = ioctl_wr && downloading && !exp_we;
            if (ioctl_wr && downloading && exp_we) begin
                exp_ovr = 1'b1;
            end else if (downloading && !dl_prev) begin
                exp_ovr = 1'b0;
            end
            if (accept && rg == rom_loader_pkg::REG_PROM) begin
                off = a - ref_prom;
                if (off < 22'd512) begin
                    ref_mem[off[8:0]] = ioctl_dout;
                end
            end else if (accept) begin
                m = (rg == rom_loader_pkg::REG_OBJ) ? obj_reorder(a) : a;
                exp_prog.addr = m[21:1];
                exp_prog.data = ioctl_dout;
                exp_prog.mask = lane_mask(m[0]);
                exp_we        = 1'b1;
            end else if (sdram_ack) begin
                exp_we = 1'b0;
            end
            exp_valid = pal_rd;
            if (pal_rd) begin
                exp_rgb = pal_entry(pal_idx);
            end
            if (cfg_wr) begin
                case (cfg.sel)
                    rom_loader_pkg::REG_SCR:  ref_scr  = cfg.start;
                    rom_loader_pkg::REG_OBJ:  ref_obj  = cfg.start;
                    rom_loader_pkg::REG_PCM:  ref_pcm  = cfg.start;
                    rom_loader_pkg::REG_PROM: ref_prom = cfg.start;
                    // Code always starts at zero
                    default: ;
                endcase
            end
            dl_prev = downloading;
        end
    end

endmodule

`default_nettype wire

/* verilog/rom_loader_top.sv */
// ROM download path with colour PROM.
// Only the low 22 bits of ioctl_addr are decoded; the upper bits of the
// 25-bit ioctl address are ignored.
// The stream has no back-pressure. The host must space bytes so that
// each SDRAM write is acknowledged before the next byte, or it is lost
// and dl_overrun is raised.

`timescale 1ns/1ps
`default_nettype none

module rom_loader_top (
    input  wire                                clk,
    input  wire                                arst_n,
    // Region table configuration
    input  wire                                cfg_wr,
    input  wire rom_loader_pkg::cfg_wr_t       cfg,
    // Download stream
    input  wire                                downloading,
    input  wire [24:0]                         ioctl_addr,
    input  wire [7:0]                          ioctl_dout,
    input  wire                                ioctl_wr,
    // SDRAM write
    output rom_loader_pkg::sdram_wr_t          prog,
    output logic                               prog_we,
    input  wire                                sdram_ack,
    // Status
    output logic                               dwnld_busy,
    output logic                               dl_overrun,
    // Palette read
    input  wire                                pal_rd,
    input  wire [rom_loader_pkg::PAL_AW-1:0]   pal_idx,
    output rom_loader_pkg::rgb_t               pal_rgb,
    output logic                               pal_valid
);

    rom_loader_pkg::region_bounds_t     bounds;
    rom_loader_pkg::region_e            region;
    logic [rom_loader_pkg::ADDR_W-1:0]  map_addr;
    logic                               prom_we;
    logic [rom_loader_pkg::PROM_AW-1:0] prom_addr;
    logic [7:0]                         prom_data;

    region_table u_region_table (
        .clk        ( clk       ),
        .arst_n     ( arst_n    ),
        .cfg_wr     ( cfg_wr    ),
        .cfg        ( cfg       ),
        .bounds     ( bounds    )
    );

    region_map u_region_map (
        .addr       ( ioctl_addr[rom_loader_pkg::ADDR_W-1:0] ),
        .bounds     ( bounds    ),
        .region     ( region    ),
        .map_addr   ( map_addr  )
    );

    dl_writer u_dl_writer (
        .clk        ( clk         ),
        .arst_n     ( arst_n      ),
        .downloading( downloading ),
        .ioctl_addr ( ioctl_addr[rom_loader_pkg::ADDR_W-1:0] ),
        .ioctl_dout ( ioctl_dout  ),
        .ioctl_wr   ( ioctl_wr    ),
        .region     ( region      ),
        .map_addr   ( map_addr    ),
        .prom_start ( bounds.prom ),
        .prog       ( prog        ),
        .prog_we    ( prog_we     ),
        .sdram_ack  ( sdram_ack   ),
        .prom_we    ( prom_we     ),
        .prom_addr  ( prom_addr   ),
        .prom_data  ( prom_data   ),
        .dwnld_busy ( dwnld_busy  ),
        .dl_overrun ( dl_overrun  )
    );

    colour_prom u_colour_prom (
        .clk        ( clk       ),
        .arst_n     ( arst_n    ),
        .prom_we    ( prom_we   ),
        .prom_addr  ( prom_addr ),
        .prom_data  ( prom_data ),
        .pal_rd     ( pal_rd    ),
        .pal_idx    ( pal_idx   ),
        .pal_rgb    ( pal_rgb   ),
        .pal_valid  ( pal_valid )
    );

endmodule

`default_nettype wire

/* verilog/colour_prom.sv */
// On-chip colour PROM, 512 bytes.
// Palette entry n uses bytes 2n and 2n+1: red and green from the even
// byte, blue from the low nibble of the odd byte. The upper nibble of
// the odd byte is stored but never shown.
// Contents are undefined until downloaded.

`timescale 1ns/1ps
`default_nettype none

module colour_prom (
    input  wire                                clk,
    input  wire                                arst_n,
    input  wire                                prom_we,
    input  wire [rom_loader_pkg::PROM_AW-1:0]  prom_addr,
    input  wire [7:0]                          prom_data,
    input  wire                                pal_rd,
    input  wire [rom_loader_pkg::PAL_AW-1:0]   pal_idx,
    output rom_loader_pkg::rgb_t               pal_rgb,
    output logic                               pal_valid
);

    // Split by byte parity so one palette read hits both halves at once
    logic [7:0] mem_even [rom_loader_pkg::PAL_N];
    logic [7:0] mem_odd  [rom_loader_pkg::PAL_N];

    always_ff @(posedge clk) begin
        if (prom_we) begin
            if (prom_addr[0]) begin
                mem_odd[prom_addr[rom_loader_pkg::PROM_AW-1:1]] <= prom_data;
            end else begin
                mem_even[prom_addr[rom_loader_pkg::PROM_AW-1:1]] <= prom_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pal_rd) begin
            pal_rgb.red   <= mem_even[pal_idx][7:4];
            pal_rgb.green <= mem_even[pal_idx][3:0];
            pal_rgb.blue  <= mem_odd[pal_idx][3:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pal_valid <= 1'b0;
        end else begin
            pal_valid <= pal_rd;
        end
    end

endmodule

`default_nettype wire

/* verilog/dl_writer.sv */
// Download byte writer.
// SDRAM bytes are held in a single write register until sdram_ack.
// The ioctl stream cannot be stalled, so a byte arriving while a write
// is pending is lost and flagged in dl_overrun until the next download.
// Even bytes land in the upper lane of the 16-bit word.
// PROM bytes beyond 512 from the PROM start are discarded.

`timescale 1ns/1ps
`default_nettype none

module dl_writer (
    input  wire                                 clk,
    input  wire                                 arst_n,
    input  wire                                 downloading,
    input  wire [rom_loader_pkg::ADDR_W-1:0]    ioctl_addr,
    input  wire [7:0]                           ioctl_dout,
    input  wire                                 ioctl_wr,
    input  wire rom_loader_pkg::region_e        region,
    input  wire [rom_loader_pkg::ADDR_W-1:0]    map_addr,
    input  wire [rom_loader_pkg::ADDR_W-1:0]    prom_start,
    output rom_loader_pkg::sdram_wr_t           prog,
    output logic                                prog_we,
    input  wire                                 sdram_ack,
    output logic                                prom_we,
    output logic [rom_loader_pkg::PROM_AW-1:0]  prom_addr,
    output logic [7:0]                          prom_data,
    output logic                                dwnld_busy,
    output logic                                dl_overrun
);

    logic                              accept;
    logic                              is_prom;
    logic                              prom_hit;
    logic [rom_loader_pkg::ADDR_W-1:0] prom_off;
    logic                              dl_last;
    logic                              dl_rise;

    // Bytes only count during a download and while no write is pending
    assign accept   = ioctl_wr & downloading & ~prog_we;
    assign is_prom  = region == rom_loader_pkg::REG_PROM;
    assign prom_off = ioctl_addr - prom_start;
    assign prom_hit = prom_off[rom_loader_pkg::ADDR_W-1:rom_loader_pkg::PROM_AW] == '0;
    assign dl_rise  = downloading & ~dl_last;

    assign dwnld_busy = downloading | prog_we;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_we    <= 1'b0;
            prom_we    <= 1'b0;
            dl_overrun <= 1'b0;
            dl_last    <= 1'b0;
        end else begin
            dl_last <= downloading;
            prom_we <= accept & is_prom & prom_hit;

            if (accept && !is_prom) begin
                prog_we <= 1'b1;
            end else if (sdram_ack) begin
                prog_we <= 1'b0;
            end

            // A new download clears the flag, a collision on the same edge still sets it
            if (ioctl_wr && downloading && prog_we) begin
                dl_overrun <= 1'b1;
            end else if (dl_rise) begin
                dl_overrun <= 1'b0;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (accept) begin
            if (is_prom) begin
                prom_addr <= prom_off[rom_loader_pkg::PROM_AW-1:0];
                prom_data <= ioctl_dout;
            end else begin
                prog.addr <= map_addr[rom_loader_pkg::ADDR_W-1:1];
                prog.data <= ioctl_dout;
                prog.mask <= map_addr[0] ? 2'b10 : 2'b01;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/region_map.sv */
// Combinational download address decoder.
// Regions are checked from the highest start downwards, which matches
// the interval rule only while the offsets are ascending.
// Object addresses get the bit order the object hardware fetches in;
// all other regions pass the address through untouched.

`timescale 1ns/1ps
`default_nettype none

module region_map (
    input  wire [rom_loader_pkg::ADDR_W-1:0]  addr,
    input  wire rom_loader_pkg::region_bounds_t bounds,
    output rom_loader_pkg::region_e           region,
    output logic [rom_loader_pkg::ADDR_W-1:0] map_addr
);

    always_comb begin
        if (addr >= bounds.prom) begin
            region = rom_loader_pkg::REG_PROM;
        end else if (addr >= bounds.pcm) begin
            region = rom_loader_pkg::REG_PCM;
        end else if (addr >= bounds.obj) begin
            region = rom_loader_pkg::REG_OBJ;
        end else if (addr >= bounds.scr) begin
            region = rom_loader_pkg::REG_SCR;
        end else begin
            region = rom_loader_pkg::REG_CODE;
        end
    end

    always_comb begin
        map_addr = addr;
        // Object line bits move up, the two upper bits drop to the bottom inverted
        if (region == rom_loader_pkg::REG_OBJ) begin
            map_addr[4:0] = {addr[2:0], ~addr[4], ~addr[3]};
        end
    end

endmodule

`default_nettype wire

/* verilog/region_table.sv */
// Run-time table of region start offsets.
// A write takes effect at the strobe edge, so bytes strobed on the
// following edge already see the new value. The code region is fixed
// at zero and writes selecting it are ignored. No ordering check is
// made between offsets; keep them ascending.

`timescale 1ns/1ps
`default_nettype none

module region_table (
    input  wire                            clk,
    input  wire                            arst_n,
    input  wire                            cfg_wr,
    input  wire rom_loader_pkg::cfg_wr_t   cfg,
    output rom_loader_pkg::region_bounds_t bounds
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bounds.scr  <= rom_loader_pkg::SCR_START_DEF;
            bounds.obj  <= rom_loader_pkg::OBJ_START_DEF;
            bounds.pcm  <= rom_loader_pkg::PCM_START_DEF;
            bounds.prom <= rom_loader_pkg::PROM_START_DEF;
        end else if (cfg_wr) begin
            case (cfg.sel)
                rom_loader_pkg::REG_SCR: begin
                    bounds.scr <= cfg.start;
                end
                rom_loader_pkg::REG_OBJ: begin
                    bounds.obj <= cfg.start;
                end
                rom_loader_pkg::REG_PCM: begin
                    bounds.pcm <= cfg.start;
                end
                rom_loader_pkg::REG_PROM: begin
                    bounds.prom <= cfg.start;
                end
                // Code region has no start register
                rom_loader_pkg::REG_CODE: begin
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/rom_loader_pkg.sv */
// Shared types and sizes for the ROM download path.
// Region start offsets below are board defaults; the region table
// can move them at run time. Offsets are byte addresses in the
// 22-bit SDRAM byte space. All SDRAM writes are single bytes
// placed on one lane of a 16-bit word.

`default_nettype none

package rom_loader_pkg;

    // Byte address width in SDRAM space and its word address width
    localparam int ADDR_W   = 22;
    localparam int SDRAM_AW = ADDR_W - 1;

    // Colour PROM: 512 bytes, two bytes per palette entry
    localparam int PROM_AW  = 9;
    localparam int PAL_AW   = PROM_AW - 1;
    localparam int PAL_N    = 1 << PAL_AW;

    // Default region start offsets
    localparam logic [ADDR_W-1:0] SCR_START_DEF  = 22'h00_8000;
    localparam logic [ADDR_W-1:0] OBJ_START_DEF  = 22'h01_0000;
    localparam logic [ADDR_W-1:0] PCM_START_DEF  = 22'h01_8000;
    localparam logic [ADDR_W-1:0] PROM_START_DEF = 22'h02_0000;

    typedef enum logic [2:0] {
        REG_CODE,
        REG_SCR,
        REG_OBJ,
        REG_PCM,
        REG_PROM
    } region_e;

    // Start offsets, code always begins at zero
    typedef struct packed {
        logic [ADDR_W-1:0] scr;
        logic [ADDR_W-1:0] obj;
        logic [ADDR_W-1:0] pcm;
        logic [ADDR_W-1:0] prom;
    } region_bounds_t;

    // One configuration write, qualified by a separate strobe
    typedef struct packed {
        region_e           sel;
        logic [ADDR_W-1:0] start;
    } cfg_wr_t;

    // Mask is active low, bit 1 for the upper lane
    typedef struct packed {
        logic [SDRAM_AW-1:0] addr;
        logic [7:0]          data;
        logic [1:0]          mask;
    } sdram_wr_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

endpackage

`default_nettype wire
